// File: common/keccak_pkg.sv
package keccak_pkg;

    // Lane and output word geometry
    localparam int w            = 64;
    localparam int w_byte_size  = w / 8;
    localparam int w_byte_width = $clog2(w_byte_size);

    // Rate in bits for each extendable-output mode
    localparam int RATE_SHAKE128 = 1344;
    localparam int RATE_SHAKE256 = 1088;

    // Whole lanes per rate block
    localparam int WORDS_SHAKE128 = RATE_SHAKE128 / w;
    localparam int WORDS_SHAKE256 = RATE_SHAKE256 / w;

    // Bytes per rate block, subtracted per squeezed block
    localparam int BYTES_SHAKE128 = WORDS_SHAKE128 * w_byte_size;
    localparam int BYTES_SHAKE256 = WORDS_SHAKE256 * w_byte_size;

    // Mode codes, lower two codes kept free for the fixed-length modes
    localparam logic [1:0] SHAKE128_MODE_VEC = 2'b10;
    localparam logic [1:0] SHAKE256_MODE_VEC = 2'b11;

endpackage

// File: common/dump_pkg.sv
package dump_pkg;

    // Squeeze controller states
    typedef enum logic [1:0] {
        state_idle    = 2'd0,
        state_request = 2'd1,
        state_shift   = 2'd2,
        state_done    = 2'd3
    } dump_state_t;

    // Enough for the 21 words of a SHAKE128 block
    localparam int WORD_COUNT_WIDTH = 5;

    // Output size arrives in bits on 32 wires, bytes need three fewer
    localparam int BYTE_COUNT_WIDTH = 29;

endpackage

// File: common/dump_ctrl_if.sv
`timescale 1ns/1ps

interface dump_ctrl_if;

    // Strobes from the controller
    logic output_buffer_we;
    logic output_buffer_shift_en;
    logic output_counter_load;
    logic valid_bytes_enable;

    // High while the head word is the final word of the current block
    logic last_word_from_block;

    modport control (
        output output_buffer_we,
        output output_buffer_shift_en,
        output output_counter_load,
        output valid_bytes_enable,
        input  last_word_from_block
    );

    modport datapath (
        input  output_buffer_we,
        input  output_buffer_shift_en,
        input  output_counter_load,
        input  valid_bytes_enable,
        output last_word_from_block
    );

endinterface

// File: dump/piso_buffer.sv
`timescale 1ns/1ps

module piso_buffer #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 21
) (
    input  logic clk,
    input  logic write_enable,
    input  logic shift_enable,
    input  logic [WIDTH*DEPTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o
);

    logic [WIDTH-1:0] words [DEPTH];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            // Word 0 sits in the lowest bits of the parallel input
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= data_i[i*WIDTH +: WIDTH];
            end
        end else if (shift_enable) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                words[i] <= words[i+1];
            end
            words[DEPTH-1] <= '0;
        end
    end

    // Head of the buffer
    assign data_o = words[0];

endmodule

// File: dump/dump_config.sv
`timescale 1ns/1ps

module dump_config (
    input  logic clk,
    input  logic rst,

    // Request from the host
    input  logic start,
    input  logic [31:0] output_size,
    input  logic [1:0] operation_mode,

    // Pulsed by the controller after every block that is not the last
    input  logic block_done,

    output logic [dump_pkg::BYTE_COUNT_WIDTH-1:0] remaining_bytes,
    output logic [1:0] cur_mode,
    output logic last_output_block
);
    import keccak_pkg::*;
    import dump_pkg::*;

    logic [BYTE_COUNT_WIDTH-1:0] block_bytes;

    // Bytes squeezed out of one block in the latched mode
    assign block_bytes = (cur_mode == SHAKE256_MODE_VEC) ?
                         BYTE_COUNT_WIDTH'(BYTES_SHAKE256) :
                         BYTE_COUNT_WIDTH'(BYTES_SHAKE128);

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining_bytes <= '0;
            cur_mode        <= SHAKE128_MODE_VEC;
        end else if (start) begin
            // Size arrives in bits and the sub-byte part is dropped
            remaining_bytes <= output_size[31:w_byte_width];
            cur_mode        <= operation_mode;
        end else if (block_done) begin
            // No underflow since block_done only comes when more than a block is owed
            remaining_bytes <= remaining_bytes - block_bytes;
        end
    end

    assign last_output_block = (remaining_bytes <= block_bytes);

    // Requests must be whole bytes and at least one byte
    a_size_whole_bytes: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (output_size != '0) && (output_size[w_byte_width-1:0] == '0)
    );

    a_mode_known: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (operation_mode == SHAKE128_MODE_VEC) ||
                  (operation_mode == SHAKE256_MODE_VEC)
    );

endmodule

// File: dump/dump_control.sv
`timescale 1ns/1ps

module dump_control (
    input  logic clk,
    input  logic rst,

    input  logic start,
    input  logic block_valid,
    input  logic last_output_block,

    dump_ctrl_if.control ctrl,

    output logic block_request,
    output logic data_valid,
    output logic done,
    output logic block_done
);
    import dump_pkg::*;

    dump_state_t state;
    dump_state_t next_state;
    logic        block_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= state_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                // Starts during any other state are dropped
                if (start) begin
                    next_state = state_request;
                end
            end
            state_request: begin
                if (block_valid) begin
                    next_state = state_shift;
                end
            end
            state_shift: begin
                if (ctrl.last_word_from_block) begin
                    if (last_output_block) begin
                        next_state = state_done;
                    end else begin
                        next_state = state_request;
                    end
                end
            end
            state_done: begin
                next_state = state_idle;
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    // Block arrives while requested
    assign block_accept = (state == state_request) && block_valid;

    // Load the buffer, word counter and last-word byte count together
    assign ctrl.output_buffer_we    = block_accept;
    assign ctrl.output_counter_load = block_accept;
    assign ctrl.valid_bytes_enable  = block_accept;

    // Head word leaves every cycle in shift
    assign ctrl.output_buffer_shift_en = (state == state_shift);

    assign block_request = (state == state_request);
    assign data_valid    = (state == state_shift);
    assign done          = (state == state_done);

    // Tells the config block to count off one more block
    assign block_done = (state == state_shift) && ctrl.last_word_from_block &&
                        !last_output_block;

    // Permutation only answers an open request
    a_valid_in_request: assert property (
        @(posedge clk) disable iff (rst)
        block_valid |-> block_request
    );

endmodule

// File: dump/dump_datapath.sv
`timescale 1ns/1ps

module dump_datapath (
    input  logic clk,
    input  logic rst,

    // Rate part of the permutation state
    input  logic [keccak_pkg::RATE_SHAKE128-1:0] rate_output,

    // From the config block
    input  logic [dump_pkg::BYTE_COUNT_WIDTH-1:0] remaining_bytes,
    input  logic [1:0] cur_mode,
    input  logic last_output_block,

    dump_ctrl_if.datapath ctrl,

    output logic [keccak_pkg::w-1:0] data_o
);
    import keccak_pkg::*;
    import dump_pkg::*;

    logic [WORD_COUNT_WIDTH-1:0] buffer_depth;
    logic [WORD_COUNT_WIDTH-1:0] remaining_words;
    logic [WORD_COUNT_WIDTH-1:0] word_count;
    logic [w_byte_width-1:0]     partial_bytes;
    logic [w_byte_width-1:0]     valid_bytes_reg;
    logic [w-1:0]                buffer_output;
    logic [w_byte_size-1:0]      zero_mask_sel;

    piso_buffer #(
        .WIDTH (w),
        .DEPTH (RATE_SHAKE128 / w)
    ) output_buffer (
        .clk          (clk),
        .write_enable (ctrl.output_buffer_we),
        .shift_enable (ctrl.output_buffer_shift_en),
        .data_i       (rate_output),
        .data_o       (buffer_output)
    );

    // Ceiling of remaining bytes over the word size, at most one block here
    assign partial_bytes   = remaining_bytes[w_byte_width-1:0];
    assign remaining_words = remaining_bytes[w_byte_width +: WORD_COUNT_WIDTH] +
                             WORD_COUNT_WIDTH'(partial_bytes != '0);

    always_comb begin
        if (last_output_block) begin
            buffer_depth = remaining_words;
        end else if (cur_mode == SHAKE256_MODE_VEC) begin
            buffer_depth = WORD_COUNT_WIDTH'(WORDS_SHAKE256);
        end else begin
            buffer_depth = WORD_COUNT_WIDTH'(WORDS_SHAKE128);
        end
    end

    // Down-counter over the words still to leave this block
    always_ff @(posedge clk) begin
        if (rst) begin
            word_count <= '0;
        end else if (ctrl.output_counter_load) begin
            word_count <= buffer_depth - 1'b1;
        end else if (ctrl.output_buffer_shift_en && (word_count != '0)) begin
            word_count <= word_count - 1'b1;
        end
    end

    assign ctrl.last_word_from_block = (word_count == '0);

    // Valid bytes in the final word, zero meaning a full word
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bytes_reg <= '0;
        end else if (ctrl.valid_bytes_enable) begin
            valid_bytes_reg <= last_output_block ? partial_bytes : '0;
        end
    end

    // Clear the low-order bytes past the requested length
    assign zero_mask_sel = (ctrl.last_word_from_block && (valid_bytes_reg != '0)) ?
                           ({w_byte_size{1'b1}} >> valid_bytes_reg) : '0;

    always_comb begin
        for (int i = 0; i < w_byte_size; i++) begin
            data_o[i*8 +: 8] = zero_mask_sel[i] ? 8'h00 : buffer_output[i*8 +: 8];
        end
    end

endmodule

// File: hw/dump_unit.sv
`timescale 1ns/1ps

module dump_unit (
    input  logic clk,
    input  logic rst,

    // Host request
    input  logic start,
    input  logic [31:0] output_size,
    input  logic [1:0] operation_mode,

    // Permutation side
    output logic block_request,
    input  logic block_valid,
    input  logic [keccak_pkg::RATE_SHAKE128-1:0] rate_output,

    // Output stream
    output logic [keccak_pkg::w-1:0] data_o,
    output logic data_valid,
    output logic done
);
    import dump_pkg::*;

    logic [BYTE_COUNT_WIDTH-1:0] remaining_bytes;
    logic [1:0]                  cur_mode;
    logic                        last_output_block;
    logic                        block_done;
    logic                        config_start;

    dump_ctrl_if ctrl_bus ();

    // Idle is the only state with all three status outputs low
    assign config_start = start && !(block_request || data_valid || done);

    dump_config config0 (
        .clk               (clk),
        .rst               (rst),
        .start             (config_start),
        .output_size       (output_size),
        .operation_mode    (operation_mode),
        .block_done        (block_done),
        .remaining_bytes   (remaining_bytes),
        .cur_mode          (cur_mode),
        .last_output_block (last_output_block)
    );

    dump_control control0 (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .block_valid       (block_valid),
        .last_output_block (last_output_block),
        .ctrl              (ctrl_bus),
        .block_request     (block_request),
        .data_valid        (data_valid),
        .done              (done),
        .block_done        (block_done)
    );

    dump_datapath datapath0 (
        .clk               (clk),
        .rst               (rst),
        .rate_output       (rate_output),
        .remaining_bytes   (remaining_bytes),
        .cur_mode          (cur_mode),
        .last_output_block (last_output_block),
        .ctrl              (ctrl_bus),
        .data_o            (data_o)
    );

endmodule

// File: testbench/tb_dump_unit.sv
`timescale 1ns/1ps

module tb_dump_unit;
    import keccak_pkg::*;

    localparam int    CLK_HALF_PERIOD = 5;
    localparam string TESTDATA_FILE   = "testbench/dump_testdata.txt";

    logic                     clk;
    logic                     rst;
    logic                     start;
    logic [31:0]              output_size;
    logic [1:0]               operation_mode;
    logic                     block_valid;
    logic [RATE_SHAKE128-1:0] rate_output;
    logic                     block_request;
    logic [w-1:0]             data_o;
    logic                     data_valid;
    logic                     done;

    int          seed = 32'h5215;
    int          valid_count = 0;
    int          watchdog_cycles = 0;
    int          case_mode[$];
    int          case_bits[$];
    int          case_delay[$];
    logic [w-1:0] block_words [WORDS_SHAKE128];

    dump_unit dut0 (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .output_size    (output_size),
        .operation_mode (operation_mode),
        .block_request  (block_request),
        .block_valid    (block_valid),
        .rate_output    (rate_output),
        .data_o         (data_o),
        .data_valid     (data_valid),
        .done           (done)
    );

    always #CLK_HALF_PERIOD clk = ~clk;

    // Counts output words as seen before the edge updates the state
    always @(posedge clk) begin
        if (data_valid) begin
            valid_count = valid_count + 1;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: actual %h expected %h at %0t", name, actual, expected, $time);
            abort_run("output check failed");
        end
    endtask

    // New random permutation output with all 21 lanes filled even in SHAKE256 mode
    task automatic fill_block();
        logic [31:0] lo;
        logic [31:0] hi;
        for (int i = 0; i < WORDS_SHAKE128; i++) begin
            lo = $random(seed);
            hi = $random(seed);
            block_words[i] = {hi, lo};
        end
    endtask

    task automatic run_case(input logic [1:0] mode, input int bits, input int delay);
        int          owed;
        int          block_bytes;
        int          n_words;
        int          first_count;
        bit          last;
        bit          first_block;
        logic [63:0] expected;
        owed = bits / 8;
        block_bytes = (mode == SHAKE256_MODE_VEC) ? 136 : 168;
        first_count = valid_count;
        first_block = 1'b1;
        @(posedge clk);
        start          <= 1'b1;
        output_size    <= bits;
        operation_mode <= mode;
        @(negedge clk);
        check_value("block_request", block_request, 0);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("block_request", block_request, 1);
        while (owed > 0) begin
            fill_block();
            for (int c = 0; c < delay; c++) begin
                @(posedge clk);
                if (first_block && c == 0) begin
                    // A second request while busy leaves the stream untouched
                    start          <= 1'b1;
                    output_size    <= 32'd8;
                    operation_mode <= mode ^ 2'b01;
                end else begin
                    start <= 1'b0;
                end
                @(negedge clk);
                check_value("block_request", block_request, 1);
                check_value("data_valid", data_valid, 0);
            end
            @(posedge clk);
            start       <= 1'b0;
            block_valid <= 1'b1;
            for (int i = 0; i < WORDS_SHAKE128; i++) begin
                rate_output[i*w +: w] <= block_words[i];
            end
            @(negedge clk);
            check_value("data_valid", data_valid, 0);
            @(posedge clk);
            block_valid <= 1'b0;
            @(negedge clk);
            check_value("block_request", block_request, 0);
            last = (owed <= block_bytes);
            n_words = last ? (owed + 7) / 8 : block_bytes / 8;
            for (int i = 0; i < n_words; i++) begin
                expected = block_words[i];
                if (last && i == n_words - 1 && (owed % 8) != 0) begin
                    // Only the top owed%8 bytes survive
                    expected = expected & ~((64'd1 << (8 * (8 - owed % 8))) - 64'd1);
                end
                check_value("data_valid", data_valid, 1);
                check_value("data_o", data_o, expected);
                @(negedge clk);
            end
            check_value("data_valid", data_valid, 0);
            owed = last ? 0 : owed - block_bytes;
            check_value("block_request", block_request, (owed > 0));
            check_value("done", done, (owed == 0));
            first_block = 1'b0;
        end
        @(negedge clk);
        check_value("done", done, 0);
        check_value("block_request", block_request, 0);
        check_value("valid_count", valid_count - first_count, (bits / 8 + 7) / 8);
    endtask

    initial begin
        int    fd;
        int    mode;
        int    bits;
        int    delay;
        int    blocks;
        string line;
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        output_size    = '0;
        operation_mode = SHAKE128_MODE_VEC;
        block_valid    = 1'b0;
        rate_output    = '0;

        fd = $fopen(TESTDATA_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the test data file");
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d", mode, bits, delay) == 3) begin
                    case_mode.push_back(mode);
                    case_bits.push_back(bits);
                    case_delay.push_back(delay);
                    blocks = (bits / 8 + ((mode == 3) ? 135 : 167)) / ((mode == 3) ? 136 : 168);
                    watchdog_cycles += blocks * (delay + 25) + 10;
                end
            end
        end
        $fclose(fd);
        if (case_mode.size() == 0) begin
            abort_run("the test data file holds no test cases");
        end
        watchdog_cycles += 10;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("block_request", block_request, 0);
        check_value("data_valid", data_valid, 0);
        check_value("done", done, 0);

        for (int n = 0; n < case_mode.size(); n++) begin
            run_case(case_mode[n], case_bits[n], case_delay[n]);
        end

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("timeout, the test cases did not finish in time");
    end

endmodule

// File: testbench/dump_testdata.txt
# mode (2 = SHAKE128, 3 = SHAKE256), output size in bits, block delay in cycles
# one test case per line
2 2688 2
3 2176 1
2 72 0
3 72 3
2 8 1
3 16 2
2 1352 1
3 1104 0
2 1336 2
3 1080 1
2 4040 4
3 3304 2
2 1344 0
3 1088 5
2 40 1
3 24 0
2 1400 3
3 1160 1
2 2696 0

// File: build.f
common/keccak_pkg.sv
common/dump_pkg.sv
common/dump_ctrl_if.sv
dump/piso_buffer.sv
dump/dump_config.sv
dump/dump_control.sv
dump/dump_datapath.sv
hw/dump_unit.sv
testbench/tb_dump_unit.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_dump_unit -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
